/* credit_counter.sv */
// Downstream credit counters, one per output port
// Decrement on grant, increment on returned credit
module credit_counter (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic [router_pkg::NUM_PORTS-1:0] dec_i,
  input  logic [router_pkg::NUM_PORTS-1:0] inc_i,
  output logic [router_pkg::NUM_PORTS-1:0] has_credit_o
);

  import router_pkg::*;

  logic [CNT_W-1:0] cnt_q [NUM_PORTS];

  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (!rst_n_i) begin
        cnt_q[o] <= CNT_W'(CREDITS);
      end else begin
        case ({inc_i[o], dec_i[o]})
          2'b10:   cnt_q[o] <= cnt_q[o] + CNT_W'(1);
          2'b01:   cnt_q[o] <= cnt_q[o] - CNT_W'(1);
          default: cnt_q[o] <= cnt_q[o];
        endcase
      end
    end
  end

  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_cc
    assign has_credit_o[g] = (cnt_q[g] != '0);

    // Allocator must not grant without credit
    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n_i)
      dec_i[g] |-> cnt_q[g] != '0)
      else $error("credit decrement at zero on output %0d", g);

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n_i)
      (inc_i[g] && !dec_i[g]) |-> cnt_q[g] < CNT_W'(CREDITS))
      else $error("credit returned beyond buffer depth on output %0d", g);
  end

endmodule

/* crossbar.sv */
// Registered 5x5 crossbar
// Each output latches the flit of its granted source
module crossbar (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  router_pkg::flit_t                flit_i  [router_pkg::NUM_PORTS],
  input  router_pkg::grant_t               grant_i [router_pkg::NUM_PORTS],
  output router_pkg::flit_t                data_o  [router_pkg::NUM_PORTS],
  output logic [router_pkg::NUM_PORTS-1:0] valid_o
);

  import router_pkg::*;

  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (grant_i[o].valid) begin
        data_o[o] <= flit_i[grant_i[o].src];
      end
    end
  end

  // One-cycle valid strobe per flit
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (!rst_n_i) begin
        valid_o[o] <= 1'b0;
      end else begin
        valid_o[o] <= grant_i[o].valid;
      end
    end
  end

endmodule

/* inner_router.sv */
// Five-port mesh router with YX routing, credit flow control
// and round-robin allocation into a registered crossbar
module inner_router (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  router_pkg::coord_t               router_xy_i,
  input  router_pkg::flit_t                data_i   [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0] valid_i,
  input  logic [router_pkg::NUM_PORTS-1:0] credit_i,
  output router_pkg::flit_t                data_o   [router_pkg::NUM_PORTS],
  output logic [router_pkg::NUM_PORTS-1:0] valid_o,
  output logic [router_pkg::NUM_PORTS-1:0] credit_o
);

  import router_pkg::*;

  flit_t                head       [NUM_PORTS];
  logic [NUM_PORTS-1:0] empty;
  route_req_t           req        [NUM_PORTS];
  logic [NUM_PORTS-1:0] has_credit;
  grant_t               grant      [NUM_PORTS];
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] dec;

  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_port
    input_buffer u_ib (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .wr_i    (valid_i[g]),
      .data_i  (data_i[g]),
      .rd_i    (pop[g]),
      .head_o  (head[g]),
      .empty_o (empty[g])
    );

    assign dec[g] = grant[g].valid;
  end

  route_compute u_rc (
    .router_xy_i (router_xy_i),
    .head_i      (head),
    .empty_i     (empty),
    .req_o       (req)
  );

  credit_counter u_cc (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .dec_i        (dec),
    .inc_i        (credit_i),
    .has_credit_o (has_credit)
  );

  switch_allocator u_sa (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .has_credit_i (has_credit),
    .grant_o      (grant),
    .pop_o        (pop)
  );

  crossbar u_xbar (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flit_i  (head),
    .grant_i (grant),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  // A popped slot is a freed slot upstream
  assign credit_o = pop;

endmodule

/* input_buffer.sv */
// Input port flit FIFO
// Head flit shown combinationally, popped on rd_i
module input_buffer (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            wr_i,
  input  router_pkg::flit_t data_i,
  input  logic            rd_i,
  output router_pkg::flit_t head_o,
  output logic            empty_o
);

  import router_pkg::*;

  flit_t            mem [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign empty_o = (count == '0);
  assign full    = (count == CNT_W'(BUF_DEPTH));
  assign head_o  = mem[rd_ptr];

  // Storage only, pointers carry the state
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (rd_i) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({wr_i, rd_i})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // Upstream must respect credits
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n_i)
    !(wr_i && full))
    else $error("write into full input buffer");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n_i)
    !(rd_i && empty_o))
    else $error("read from empty input buffer");

endmodule

/* route_compute.sv */
// YX dimension-ordered route decision for every input head flit
module route_compute (
  input  router_pkg::coord_t     router_xy_i,
  input  router_pkg::flit_t      head_i [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0] empty_i,
  output router_pkg::route_req_t req_o [router_pkg::NUM_PORTS]
);

  import router_pkg::*;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      req_o[i].req = !empty_i[i];
      // Y first, then X
      if (head_i[i].dest.y > router_xy_i.y) begin
        req_o[i].port = PORT_N;
      end else if (head_i[i].dest.y < router_xy_i.y) begin
        req_o[i].port = PORT_S;
      end else if (head_i[i].dest.x > router_xy_i.x) begin
        req_o[i].port = PORT_E;
      end else if (head_i[i].dest.x < router_xy_i.x) begin
        req_o[i].port = PORT_W;
      end else begin
        req_o[i].port = PORT_L;
      end
    end
  end

endmodule

/* router_cases.txt */
# name in_port dest_x dest_y payload expected_out ; router sits at x 2, y 2
# ports 0 N, 1 E, 2 S, 3 W, 4 L ; coordinates and payload in hex
local_from_n 0 2 2 a1 4
local_from_e 1 2 2 a2 4
local_from_s 2 2 2 a3 4
local_from_w 3 2 2 a4 4
local_from_l 4 2 2 a5 4
l_to_n 4 2 3 b1 0
l_to_e 4 3 2 b2 1
l_to_s 4 2 1 b3 2
l_to_w 4 1 2 b4 3
s_to_n 2 2 5 c1 0
n_to_s 0 2 0 c2 2
w_to_e 3 7 2 c3 1
e_to_w 1 0 2 c4 3
n_to_e 0 3 2 c5 1
s_to_w 2 1 2 c6 3
e_y_first 1 0 3 c7 0
w_y_first 3 3 1 c8 2
corner_ff 4 f f c9 0
corner_00 4 0 0 ca 2

/* router_pkg.sv */
// Shared types and sizing for the five-port mesh router
// Port order N, E, S, W, L is used by every per-port array
package router_pkg;

  localparam int NUM_PORTS = 5;
  localparam int COORD_W   = 4;
  localparam int PAYLOAD_W = 8;
  localparam int BUF_DEPTH = 4;
  // Downstream router has the same buffers
  localparam int CREDITS   = BUF_DEPTH;
  localparam int PTR_W     = $clog2(BUF_DEPTH);
  localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

  typedef logic [2:0] port_t;

  localparam port_t PORT_N = 3'd0;
  localparam port_t PORT_E = 3'd1;
  localparam port_t PORT_S = 3'd2;
  localparam port_t PORT_W = 3'd3;
  localparam port_t PORT_L = 3'd4;

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } coord_t;

  typedef struct packed {
    coord_t               dest;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  typedef struct packed {
    logic  req;
    port_t port;
  } route_req_t;

  typedef struct packed {
    logic  valid;
    port_t src;
  } grant_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_inner_router -o tb_inner_router
./obj_dir/tb_inner_router > sim.log 2>&1
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

/* sim.f */
router_pkg.sv
input_buffer.sv
route_compute.sv
credit_counter.sv
switch_allocator.sv
crossbar.sv
inner_router.sv
tb_clock_gen.sv
tb_inner_router.sv

/* switch_allocator.sv */
// Round-robin switch allocator
// Each output goes to at most one requesting input while it has credit
module switch_allocator (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  router_pkg::route_req_t           req_i [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0] has_credit_i,
  output router_pkg::grant_t               grant_o [router_pkg::NUM_PORTS],
  output logic [router_pkg::NUM_PORTS-1:0] pop_o
);

  import router_pkg::*;

  // Highest priority input per output
  port_t                ptr_q [NUM_PORTS];
  // win[i][o] set when input i owns output o
  logic [NUM_PORTS-1:0] win   [NUM_PORTS];

  always_comb begin
    int idx;
    for (int o = 0; o < NUM_PORTS; o++) begin
      grant_o[o] = '0;
      for (int k = 0; k < NUM_PORTS; k++) begin
        idx = int'(ptr_q[o]) + k;
        if (idx >= NUM_PORTS) begin
          idx = idx - NUM_PORTS;
        end
        if (!grant_o[o].valid && has_credit_i[o] && req_i[idx].req &&
            req_i[idx].port == port_t'(o)) begin
          grant_o[o].valid = 1'b1;
          grant_o[o].src   = port_t'(idx);
        end
      end
    end

    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        win[i][o] = grant_o[o].valid && (grant_o[o].src == port_t'(i));
      end
      pop_o[i] = |win[i];
    end
  end

  // Next search starts just after the winner
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (!rst_n_i) begin
        ptr_q[o] <= PORT_N;
      end else if (grant_o[o].valid) begin
        if (grant_o[o].src == PORT_L) begin
          ptr_q[o] <= PORT_N;
        end else begin
          ptr_q[o] <= grant_o[o].src + port_t'(1);
        end
      end
    end
  end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 10 cycles
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #5 rst_n_o = 1'b1;
  end

endmodule

/* tb_inner_router.sv */
// Testbench for the five-port mesh router
// Replays the flit cases, then checks arbitration and credit flow
module tb_inner_router;
  timeunit 1ns;
  timeprecision 100ps;

  import router_pkg::*;

  localparam int DLY   = 5;
  localparam int LIMIT = 200;

  logic                 clk;
  logic                 rst_n;
  coord_t               router_xy;
  flit_t                data_i [NUM_PORTS];
  logic [NUM_PORTS-1:0] valid_i;
  logic [NUM_PORTS-1:0] credit_i;
  flit_t                data_o [NUM_PORTS];
  logic [NUM_PORTS-1:0] valid_o;
  logic [NUM_PORTS-1:0] credit_o;

  // Every delivered flit per output, with the cycle it was seen
  flit_t                out_q [NUM_PORTS][$];
  int                   out_t [NUM_PORTS][$];
  int                   rd_idx   [NUM_PORTS] = '{default: 0};
  int                   sent_cnt [NUM_PORTS] = '{default: 0};
  int                   cred_cnt [NUM_PORTS] = '{default: 0};
  logic [NUM_PORTS-1:0] hold_mask = '0;
  logic [NUM_PORTS-1:0] ret_next  = '0;
  int                   pulse_req = 0;
  int                   pulse_ack = 0;
  int                   cycle     = 0;
  int                   fails     = 0;
  int                   timeouts  = 0;

  // Contending inputs per round and the expected winner order
  int rr_src [2][3] = '{'{0, 1, 2}, '{0, 1, 4}};
  int rr_exp [2][3] = '{'{0, 1, 2}, '{4, 0, 1}};

  assign router_xy = '{x: 4'd2, y: 4'd2};

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  inner_router UUT (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .router_xy_i (router_xy),
    .data_i      (data_i),
    .valid_i     (valid_i),
    .credit_i    (credit_i),
    .data_o      (data_o),
    .valid_o     (valid_o),
    .credit_o    (credit_o)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Downstream model returns a credit one cycle after each flit
  always @(negedge clk) begin
    ret_next = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (rst_n && valid_o[o]) begin
        out_q[o].push_back(data_o[o]);
        out_t[o].push_back(cycle);
        ret_next[o] = !hold_mask[o];
      end
      if (rst_n && credit_o[o]) begin
        cred_cnt[o]++;
      end
    end
    if (pulse_ack != pulse_req) begin
      ret_next[PORT_E] = 1'b1;
      pulse_ack++;
    end
  end

  initial begin
    credit_i = '0;
    forever begin
      @(posedge clk);
      #DLY;
      credit_i = ret_next;
    end
  end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      fails++;
    end
  endtask

  task automatic finish_run();
    $display("Error counts: %0d failed checks, %0d timeouts", fails, timeouts);
    if (fails + timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    timeouts++;
    finish_run();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DLY;
  endtask

  function automatic flit_t make_flit(input int x, input int y, input int pl);
    flit_t f;
    f.dest.x  = x[COORD_W-1:0];
    f.dest.y  = y[COORD_W-1:0];
    f.payload = pl[PAYLOAD_W-1:0];
    return f;
  endfunction

  // Sender side obeys credit_o of the input it writes
  task automatic stage_flit(input int p, input flit_t f);
    int n;
    for (n = 0; n < LIMIT && sent_cnt[p] - cred_cnt[p] >= BUF_DEPTH; n++) begin
      next_cycle();
    end
    if (n == LIMIT) begin
      timed_out("an input buffer credit");
    end
    data_i[p]  = f;
    valid_i[p] = 1'b1;
    sent_cnt[p]++;
  endtask

  task automatic send_cycle();
    next_cycle();
    valid_i = '0;
  endtask

  task automatic wait_flits(input int p, input int n, input string what);
    int k;
    for (k = 0; k < LIMIT && out_q[p].size() < rd_idx[p] + n; k++) begin
      next_cycle();
    end
    if (out_q[p].size() < rd_idx[p] + n) begin
      timed_out(what);
    end
  endtask

  // Whole flit is compared, destination and payload
  task automatic expect_flit(input int p, input string name, input flit_t exp_f,
                             output int t);
    wait_flits(p, 1, name);
    check_value(name, int'(exp_f), int'(out_q[p][rd_idx[p]]));
    t = out_t[p][rd_idx[p]];
    rd_idx[p]++;
  endtask

  initial begin
    int    fd;
    int    n;
    int    t;
    int    t0;
    int    wcyc;
    int    ncases;
    int    gap;
    int    ip, dx, dy, pl, ep;
    string line;
    string name;
    flit_t f;

    void'($urandom(32'h083e_bc6f));
    valid_i = '0;
    ncases  = 0;
    t0      = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      data_i[p] = '0;
    end
    for (n = 0; n < LIMIT && !rst_n; n++) begin
      next_cycle();
    end
    if (!rst_n) begin
      timed_out("reset release");
    end

    repeat (5) begin
      next_cycle();
      check_value("idle valid_o", 0, int'(valid_o));
      check_value("idle credit_o", 0, int'(credit_o));
    end

    // Local output contended by three inputs, twice
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < 3; k++) begin
        stage_flit(rr_src[r][k], make_flit(2, 2, 16 * (r + 1) + rr_src[r][k]));
      end
      send_cycle();
      for (int k = 0; k < 3; k++) begin
        expect_flit(int'(PORT_L), "round robin order",
                    make_flit(2, 2, 16 * (r + 1) + rr_exp[r][k]), t);
        if (k == 0) begin
          t0 = t;
        end
        check_value("round robin spacing", t0 + k, t);
      end
    end

    fd = $fopen("router_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file router_cases.txt");
      fails++;
    end else begin
      for (int ln = 0; ln < 256 && !$feof(fd); ln++) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%s %d %h %h %h %d", name, ip, dx, dy, pl, ep) == 6) begin
          f = make_flit(dx, dy, pl);
          stage_flit(ip, f);
          wcyc = cycle;
          send_cycle();
          expect_flit(ep, name, f, t);
          check_value({name, " latency"}, 2, t - wcyc);
          ncases++;
          gap = $urandom_range(3, 0);
          repeat (gap) next_cycle();
        end
      end
      $fclose(fd);
      if (ncases == 0) begin
        $display("No usable cases were found in router_cases.txt");
        fails++;
      end
    end

    // East downstream keeps its credits
    hold_mask[PORT_E] = 1'b1;
    for (int k = 0; k < CREDITS + 2; k++) begin
      stage_flit(int'(PORT_L), make_flit(3, 2, 'h40 + k));
      send_cycle();
    end
    wait_flits(int'(PORT_E), CREDITS, "east flits before credit stall");
    repeat (8) next_cycle();
    check_value("east stalled count", rd_idx[PORT_E] + CREDITS, out_q[PORT_E].size());
    for (int k = 0; k < CREDITS; k++) begin
      expect_flit(int'(PORT_E), "east before stall", make_flit(3, 2, 'h40 + k), t);
    end
    for (int k = CREDITS; k < CREDITS + 2; k++) begin
      pulse_req++;
      expect_flit(int'(PORT_E), "east one per credit", make_flit(3, 2, 'h40 + k), t);
      repeat (6) next_cycle();
      check_value("east extra flits", rd_idx[PORT_E], out_q[PORT_E].size());
    end
    pulse_req += CREDITS;
    for (n = 0; n < LIMIT && pulse_ack != pulse_req; n++) begin
      next_cycle();
    end
    if (pulse_ack != pulse_req) begin
      timed_out("east credit pulses");
    end
    hold_mask = '0;

    // Drain, then every write must have been answered by one credit_o
    for (n = 0; n < LIMIT && sent_cnt != cred_cnt; n++) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value("credit_o pulses", sent_cnt[p], cred_cnt[p]);
      check_value("unexpected output flits", rd_idx[p], out_q[p].size());
    end
    finish_run();
  end

endmodule
